// File: source/exu_defs.svh
// --------------------
// Width macros for the execute stage
// Data word, micro-op, unit select, register address, instruction
// --------------------
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// Data path
// --------------------
`define EXU_XLEN     32   // Data word width

// Dispatch fields
// --------------------
`define EXU_UOP_W    5    // Micro-op code width
`define EXU_FU_W     4    // One-hot functional unit width

// Register file and fetch
// --------------------
`define EXU_RD_W     5    // Destination register address width
`define EXU_INSTR_W  32   // Raw instruction word width

`endif

// File: source/exu_pkg.sv
// --------------------
// Execute stage types and code constants
// Micro-ops, unit bit positions, trap cause, ALU control
// --------------------
`include "exu_defs.svh"

package exu_pkg;

    typedef logic [`EXU_XLEN-1:0]    xword_t;     // Data word
    typedef logic [`EXU_UOP_W-1:0]   uop_t;       // Micro-op code
    typedef logic [`EXU_FU_W-1:0]    fu_t;        // One-hot unit select
    typedef logic [`EXU_RD_W-1:0]    reg_addr_t;  // Register address
    typedef logic [1:0]              size_t;      // Instruction size
    typedef logic [`EXU_INSTR_W-1:0] instr_t;     // Instruction word
    typedef logic [3:0]              alu_ctl_t;   // Internal ALU select

    // Unit select bits
    localparam int FU_ALU = 0;
    localparam int FU_LSU = 1;
    localparam int FU_CFU = 2;
    localparam int FU_CSR = 3;

    // ALU micro-ops
    localparam uop_t ALU_ADD  = 5'd1;
    localparam uop_t ALU_SUB  = 5'd2;
    localparam uop_t ALU_XOR  = 5'd3;
    localparam uop_t ALU_OR   = 5'd4;
    localparam uop_t ALU_AND  = 5'd5;
    localparam uop_t ALU_SLL  = 5'd6;
    localparam uop_t ALU_SRL  = 5'd7;
    localparam uop_t ALU_SRA  = 5'd8;
    localparam uop_t ALU_ROR  = 5'd9;
    localparam uop_t ALU_ROL  = 5'd10;
    localparam uop_t ALU_SLT  = 5'd11;
    localparam uop_t ALU_SLTU = 5'd12;

    // CFU micro-ops, top bits 00 conditional, 10 unconditional
    localparam uop_t CFU_BEQ       = 5'b00_001;
    localparam uop_t CFU_BNE       = 5'b00_010;
    localparam uop_t CFU_BLT       = 5'b00_011;
    localparam uop_t CFU_BGE       = 5'b00_100;
    localparam uop_t CFU_BLTU      = 5'b00_101;
    localparam uop_t CFU_BGEU      = 5'b00_110;
    localparam uop_t CFU_JALI      = 5'b10_001;
    localparam uop_t CFU_JALR      = 5'b10_010;
    localparam uop_t CFU_JMP       = 5'b10_011;
    localparam uop_t CFU_TAKEN     = 5'b11_001;  // Resolved branch codes
    localparam uop_t CFU_NOT_TAKEN = 5'b11_010;

    // LSU micro-op flag bits
    localparam int LSU_LOAD  = 3;
    localparam int LSU_STORE = 4;

    localparam int TRAP_CAUSE_W = 6;  // Cause field inside operand B

    // ALU control codes
    localparam alu_ctl_t ACTL_ADD = 4'd0;
    localparam alu_ctl_t ACTL_SUB = 4'd1;
    localparam alu_ctl_t ACTL_XOR = 4'd2;
    localparam alu_ctl_t ACTL_OR  = 4'd3;
    localparam alu_ctl_t ACTL_AND = 4'd4;
    localparam alu_ctl_t ACTL_SLL = 4'd5;
    localparam alu_ctl_t ACTL_SRL = 4'd6;
    localparam alu_ctl_t ACTL_SRA = 4'd7;
    localparam alu_ctl_t ACTL_ROR = 4'd8;
    localparam alu_ctl_t ACTL_ROL = 4'd9;
    localparam alu_ctl_t ACTL_SLT = 4'd10;  // Compare, signedness apart

endpackage

// File: source/exu_decode.sv
// --------------------
// Execute stage decode
// Micro-op to ALU control and branch kind selects
// --------------------
`timescale 1ns/10ps

module exu_decode import exu_pkg::*; (
    input  uop_t     i_uop,           // Micro-op code
    input  fu_t      i_fu,            // One-hot unit select
    output alu_ctl_t o_alu_ctl,       // ALU operation
    output logic     o_cmp_unsigned,  // Unsigned compare
    output logic     o_br_cond,       // Conditional branch
    output logic     o_br_eq,         // beq
    output logic     o_br_ne,         // bne
    output logic     o_br_lt,         // blt / bltu
    output logic     o_br_ge,         // bge / bgeu
    output logic     o_jalr           // Target from adder
);

    logic fu_alu;
    logic fu_cfu;
    logic cfu_cond;

    assign fu_alu   = i_fu[FU_ALU];
    assign fu_cfu   = i_fu[FU_CFU];
    assign cfu_cond = fu_cfu && (i_uop[$bits(uop_t)-1 -: 2] == 2'b00);

    // Branch kind selects
    assign o_br_cond = cfu_cond;
    assign o_br_eq   = cfu_cond && (i_uop == CFU_BEQ);
    assign o_br_ne   = cfu_cond && (i_uop == CFU_BNE);
    assign o_br_lt   = cfu_cond && (i_uop == CFU_BLT || i_uop == CFU_BLTU);
    assign o_br_ge   = cfu_cond && (i_uop == CFU_BGE || i_uop == CFU_BGEU);
    assign o_jalr    = fu_cfu && (i_uop == CFU_JALR);

    assign o_cmp_unsigned = (fu_alu && i_uop == ALU_SLTU) ||
                            (cfu_cond && (i_uop == CFU_BLTU || i_uop == CFU_BGEU));

    always_comb begin
        o_alu_ctl = ACTL_ADD;             // Sum for LSU, jalr, CSR
        if (cfu_cond) begin
            o_alu_ctl = ACTL_SLT;         // Branches need lt / eq only
        end else if (fu_alu) begin
            case (i_uop)
                ALU_ADD:           o_alu_ctl = ACTL_ADD;
                ALU_SUB:           o_alu_ctl = ACTL_SUB;
                ALU_XOR:           o_alu_ctl = ACTL_XOR;
                ALU_OR:            o_alu_ctl = ACTL_OR;
                ALU_AND:           o_alu_ctl = ACTL_AND;
                ALU_SLL:           o_alu_ctl = ACTL_SLL;
                ALU_SRL:           o_alu_ctl = ACTL_SRL;
                ALU_SRA:           o_alu_ctl = ACTL_SRA;
                ALU_ROR:           o_alu_ctl = ACTL_ROR;
                ALU_ROL:           o_alu_ctl = ACTL_ROL;
                ALU_SLT, ALU_SLTU: o_alu_ctl = ACTL_SLT;
                default:           o_alu_ctl = ACTL_ADD;
            endcase
        end
    end

    // Upstream dispatches to at most one unit
    always_comb begin
        if (!$isunknown(i_fu)) begin
            a_fu_onehot: assert ($onehot0(i_fu))
                else $error("exu_decode: unit select %b is not one-hot", i_fu);
        end
    end

endmodule

// File: source/exu_alu.sv
// --------------------
// Single cycle integer ALU
// Adder, logic, shift / rotate, compare
// --------------------
`timescale 1ns/10ps

module exu_alu import exu_pkg::*; (
    input  alu_ctl_t i_ctl,         // Operation select
    input  logic     i_unsigned,    // Unsigned compare
    input  xword_t   i_lhs,         // Left operand
    input  xword_t   i_rhs,         // Right operand
    output xword_t   o_result,      // Selected result
    output xword_t   o_add_result,  // Plain sum, always valid
    output logic     o_lt,          // lhs < rhs
    output logic     o_eq           // lhs == rhs
);

    localparam int XW  = $bits(xword_t);
    localparam int SHW = $clog2(XW);

    logic            lhs_top;   // Compare extension bits
    logic            rhs_top;
    logic [XW:0]     diff;      // Extended difference
    logic [SHW-1:0]  shamt;
    logic [2*XW-1:0] rot_r;     // Doubled word for rotates
    logic [2*XW-1:0] rot_l;

    assign o_add_result = i_lhs + i_rhs;

    // Sign extend for signed compare, zero extend for unsigned
    assign lhs_top = !i_unsigned && i_lhs[XW-1];
    assign rhs_top = !i_unsigned && i_rhs[XW-1];
    assign diff    = {lhs_top, i_lhs} - {rhs_top, i_rhs};  // Cannot overflow
    assign o_lt    = diff[XW];
    assign o_eq    = (i_lhs == i_rhs);

    // Shifter
    // --------------------
    assign shamt = i_rhs[SHW-1:0];             // Low bits only
    assign rot_r = {i_lhs, i_lhs} >> shamt;
    assign rot_l = {i_lhs, i_lhs} << shamt;

    always_comb begin
        case (i_ctl)
            ACTL_ADD: o_result = o_add_result;
            ACTL_SUB: o_result = diff[XW-1:0];
            ACTL_XOR: o_result = i_lhs ^ i_rhs;
            ACTL_OR:  o_result = i_lhs | i_rhs;
            ACTL_AND: o_result = i_lhs & i_rhs;
            ACTL_SLL: o_result = i_lhs << shamt;
            ACTL_SRL: o_result = i_lhs >> shamt;
            ACTL_SRA: o_result = xword_t'($signed(i_lhs) >>> shamt);
            ACTL_ROR: o_result = rot_r[XW-1:0];
            ACTL_ROL: o_result = rot_l[2*XW-1:XW];
            ACTL_SLT: o_result = xword_t'(o_lt);  // 0 / 1
            default:  o_result = o_add_result;
        endcase
    end

endmodule

// File: source/exu_result.sv
// --------------------
// Per-unit result select and branch resolution
// Trap cause, operand load enables, forwarding
// --------------------
`timescale 1ns/10ps

module exu_result import exu_pkg::*; (
    input  fu_t       i_fu,          // One-hot unit select
    input  uop_t      i_uop,         // Incoming micro-op
    input  reg_addr_t i_rd,          // Destination / trap code
    input  logic      i_trap,        // Trap raised upstream
    input  xword_t    i_opr_a,       // Operand A
    input  xword_t    i_opr_c,       // Operand C
    input  xword_t    i_alu_result,  // ALU result
    input  xword_t    i_add_result,  // A + B
    input  logic      i_lt,          // Compare less-than
    input  logic      i_eq,          // Compare equal
    input  logic      i_br_cond,     // Conditional branch
    input  logic      i_br_eq,
    input  logic      i_br_ne,
    input  logic      i_br_lt,
    input  logic      i_br_ge,
    input  logic      i_jalr,        // Target from adder
    input  logic      i_accept,      // Transfer this cycle
    output xword_t    o_opr_a,       // Next s3 operand A
    output xword_t    o_opr_b,       // Next s3 operand B
    output uop_t      o_uop,         // Next s3 micro-op
    output logic      o_opra_ld,     // Operand A load enable
    output logic      o_oprb_ld,     // Operand B load enable
    output xword_t    o_fwd_wdata,   // Forwarded write data
    output logic      o_fwd_load,    // Load in flight
    output logic      o_fwd_csr      // CSR op in flight
);

    localparam int XW = $bits(xword_t);

    logic                    fu_alu;
    logic                    fu_lsu;
    logic                    fu_cfu;
    logic                    fu_csr;
    logic                    lsu_load;
    logic                    lsu_store;
    logic                    br_taken;
    xword_t                  cfu_target;
    logic [TRAP_CAUSE_W-1:0] trap_cause;

    assign fu_alu    = i_fu[FU_ALU];
    assign fu_lsu    = i_fu[FU_LSU];
    assign fu_cfu    = i_fu[FU_CFU];
    assign fu_csr    = i_fu[FU_CSR];
    assign lsu_load  = fu_lsu && i_uop[LSU_LOAD];
    assign lsu_store = fu_lsu && i_uop[LSU_STORE];

    // Branch resolution
    // --------------------
    assign br_taken = (i_br_eq &&  i_eq) || (i_br_ne && !i_eq) ||
                      (i_br_lt &&  i_lt) || (i_br_ge && !i_lt);  // ge is !lt
    assign o_uop    = i_br_cond ? (br_taken ? CFU_TAKEN : CFU_NOT_TAKEN) : i_uop;

    // Jump target, bit 0 always cleared
    assign cfu_target = i_jalr ? (i_add_result & ~xword_t'(1)) :
                                 (i_opr_c      & ~xword_t'(1));

    assign o_opr_a = ({XW{fu_alu}} & i_alu_result) |
                     ({XW{fu_lsu}} & i_add_result) |  // Memory address
                     ({XW{fu_cfu}} & cfu_target)   |
                     ({XW{fu_csr}} & i_opr_a);

    assign trap_cause = TRAP_CAUSE_W'(i_rd);
    assign o_opr_b    = i_trap ? xword_t'(trap_cause) :       // Trap first
                        ({XW{fu_lsu || fu_csr}} & i_opr_c);   // Store / CSR data

    assign o_opra_ld = i_accept;
    assign o_oprb_ld = i_accept && (lsu_store || fu_csr || i_trap);

    // Forwarding
    assign o_fwd_wdata = o_opr_a;
    assign o_fwd_load  = lsu_load;
    assign o_fwd_csr   = fu_csr;

endmodule

// File: source/exu_pipe_reg.sv
// --------------------
// Execute to writeback stage register
// Valid / stall / flush, separately loaded operands
// --------------------
`timescale 1ns/10ps

module exu_pipe_reg import exu_pkg::*; (
    input  logic      g_clk,
    input  logic      g_resetn,
    input  logic      i_flush,    // Drop held item
    input  logic      i_valid,    // Ungated s2 valid
    input  logic      i_busy,     // s3 busy
    input  logic      i_opra_ld,  // Operand A enable
    input  logic      i_oprb_ld,  // Operand B enable
    input  reg_addr_t i_rd,
    input  uop_t      i_uop,
    input  fu_t       i_fu,
    input  logic      i_trap,
    input  size_t     i_size,
    input  instr_t    i_instr,
    input  xword_t    i_opr_a,
    input  xword_t    i_opr_b,
    output logic      o_busy,     // Stage cannot take input
    output logic      o_valid,    // Item held
    output reg_addr_t o_rd,
    output uop_t      o_uop,
    output fu_t       o_fu,
    output logic      o_trap,
    output size_t     o_size,
    output instr_t    o_instr,
    output xword_t    o_opr_a,
    output xword_t    o_opr_b
);

    logic accept;

    assign o_busy = o_valid && i_busy;   // Only downstream stalls us
    assign accept = i_valid && !o_busy;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_valid <= 1'b0;
        end else if (i_flush) begin
            o_valid <= 1'b0;             // Flush beats a load
        end else if (!o_busy) begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            o_rd    <= i_rd;
            o_uop   <= i_uop;
            o_fu    <= i_fu;
            o_trap  <= i_trap;
            o_size  <= i_size;
            o_instr <= i_instr;
        end
    end

    // Operand B holds across ops that leave it alone
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_opr_a <= '0;
            o_opr_b <= '0;
        end else begin
            if (i_opra_ld) begin
                o_opr_a <= i_opr_a;
            end
            if (i_oprb_ld) begin
                o_opr_b <= i_opr_b;
            end
        end
    end

    // Operand enables come from outside and must respect the stall
    a_hold_stable: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (o_valid && i_busy) |=> $stable({o_rd, o_uop, o_fu, o_trap, o_size,
                                         o_instr, o_opr_a, o_opr_b}))
        else $error("exu_pipe_reg: s3 outputs changed while stalled");

endmodule

// File: source/exu_top.sv
// --------------------
// Execute stage top level
// Decode, ALU, result select, stage register
// --------------------
`timescale 1ns/10ps

module exu_top import exu_pkg::*; (
    input  logic      g_clk,
    input  logic      g_resetn,
    // Upstream side
    input  logic      i_s2_valid,
    input  reg_addr_t i_s2_rd,
    input  xword_t    i_s2_opr_a,
    input  xword_t    i_s2_opr_b,
    input  xword_t    i_s2_opr_c,
    input  uop_t      i_s2_uop,
    input  fu_t       i_s2_fu,
    input  logic      i_s2_trap,
    input  size_t     i_s2_size,
    input  instr_t    i_s2_instr,
    input  logic      i_flush,
    output logic      o_s2_busy,
    // Downstream side
    input  logic      i_s3_busy,
    output logic      o_s3_valid,
    output reg_addr_t o_s3_rd,
    output uop_t      o_s3_uop,
    output fu_t       o_s3_fu,
    output logic      o_s3_trap,
    output size_t     o_s3_size,
    output instr_t    o_s3_instr,
    output xword_t    o_s3_opr_a,
    output xword_t    o_s3_opr_b,
    // Writeback forwarding
    output reg_addr_t o_fwd_rd,
    output xword_t    o_fwd_wdata,
    output logic      o_fwd_load,
    output logic      o_fwd_csr
);

    alu_ctl_t alu_ctl;
    logic     cmp_unsigned;
    logic     br_cond;
    logic     br_eq;
    logic     br_ne;
    logic     br_lt;
    logic     br_ge;
    logic     jalr;
    xword_t   alu_result;
    xword_t   add_result;
    logic     alu_lt;
    logic     alu_eq;
    xword_t   n_opr_a;       // Next s3 operands
    xword_t   n_opr_b;
    uop_t     n_uop;
    logic     opra_ld;
    logic     oprb_ld;
    logic     s2_accept;     // Transfer this cycle

    assign s2_accept = i_s2_valid && !o_s2_busy;
    assign o_fwd_rd  = i_s2_rd;

    exu_decode u_decode (
        .i_uop(i_s2_uop), .i_fu(i_s2_fu),
        .o_alu_ctl(alu_ctl), .o_cmp_unsigned(cmp_unsigned),
        .o_br_cond(br_cond), .o_br_eq(br_eq), .o_br_ne(br_ne),
        .o_br_lt(br_lt), .o_br_ge(br_ge), .o_jalr(jalr)
    );

    exu_alu u_alu (
        .i_ctl(alu_ctl), .i_unsigned(cmp_unsigned),
        .i_lhs(i_s2_opr_a), .i_rhs(i_s2_opr_b),
        .o_result(alu_result), .o_add_result(add_result),
        .o_lt(alu_lt), .o_eq(alu_eq)
    );

    exu_result u_result (
        .i_fu(i_s2_fu), .i_uop(i_s2_uop), .i_rd(i_s2_rd), .i_trap(i_s2_trap),
        .i_opr_a(i_s2_opr_a), .i_opr_c(i_s2_opr_c),
        .i_alu_result(alu_result), .i_add_result(add_result),
        .i_lt(alu_lt), .i_eq(alu_eq),
        .i_br_cond(br_cond), .i_br_eq(br_eq), .i_br_ne(br_ne),
        .i_br_lt(br_lt), .i_br_ge(br_ge), .i_jalr(jalr), .i_accept(s2_accept),
        .o_opr_a(n_opr_a), .o_opr_b(n_opr_b), .o_uop(n_uop),
        .o_opra_ld(opra_ld), .o_oprb_ld(oprb_ld),
        .o_fwd_wdata(o_fwd_wdata), .o_fwd_load(o_fwd_load), .o_fwd_csr(o_fwd_csr)
    );

    exu_pipe_reg u_pipe_reg (
        .g_clk(g_clk), .g_resetn(g_resetn), .i_flush(i_flush),
        .i_valid(i_s2_valid), .i_busy(i_s3_busy),
        .i_opra_ld(opra_ld), .i_oprb_ld(oprb_ld),
        .i_rd(i_s2_rd), .i_uop(n_uop), .i_fu(i_s2_fu), .i_trap(i_s2_trap),
        .i_size(i_s2_size), .i_instr(i_s2_instr),
        .i_opr_a(n_opr_a), .i_opr_b(n_opr_b),
        .o_busy(o_s2_busy), .o_valid(o_s3_valid),
        .o_rd(o_s3_rd), .o_uop(o_s3_uop), .o_fu(o_s3_fu), .o_trap(o_s3_trap),
        .o_size(o_s3_size), .o_instr(o_s3_instr),
        .o_opr_a(o_s3_opr_a), .o_opr_b(o_s3_opr_b)
    );

endmodule

// File: tests/tb_clock.sv
// --------------------
// Testbench clock and reset
// 40 ns period, reset low for 3 cycles
// --------------------
`timescale 1ns/10ps

module tb_clock (
    output logic g_clk,
    output logic g_resetn
);

    localparam int HALF_PERIOD = 20;    // ns

    initial begin
        g_clk = 1'b0;
        forever #(HALF_PERIOD) g_clk = ~g_clk;
    end

    initial begin
        g_resetn = 1'b0;                // Low from time zero
        repeat (3) @(posedge g_clk);
        g_resetn <= 1'b1;               // Released after third edge
    end

endmodule

// File: tests/tb_exu.sv
// --------------------
// Execute stage testbench
// Random ops from a fixed seed, reference model
// Compare tasks and the test sequence
// --------------------
`timescale 1ns/10ps

module tb_exu import exu_pkg::*; ();

    localparam int   TIMEOUT_CYCLES = 64;                    // Per-wait limit
    localparam uop_t LD_FLAG = uop_t'(1) << LSU_LOAD;
    localparam uop_t ST_FLAG = uop_t'(1) << LSU_STORE;

    logic      g_clk, g_resetn;
    logic      s2_valid, s2_trap, flush, s3_busy;            // DUT inputs
    reg_addr_t s2_rd;
    xword_t    s2_opr_a, s2_opr_b, s2_opr_c;
    uop_t      s2_uop;
    fu_t       s2_fu;
    size_t     s2_size;
    instr_t    s2_instr;
    logic      s2_busy, s3_valid, s3_trap, fwd_load, fwd_csr; // DUT outputs
    reg_addr_t s3_rd, fwd_rd;
    uop_t      s3_uop;
    fu_t       s3_fu;
    size_t     s3_size;
    instr_t    s3_instr;
    xword_t    s3_opr_a, s3_opr_b, fwd_wdata;
    logic      m_valid, m_trap;                              // Expected s3 contents
    reg_addr_t m_rd;
    uop_t      m_uop;
    fu_t       m_fu;
    size_t     m_size;
    instr_t    m_instr;
    xword_t    m_opr_a = '0;
    xword_t    m_opr_b = '0;                                 // Held operand B
    integer    seed;
    int        errors, checks, sent, delivered;

    uop_t alu_ops [12] = '{ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL,
                           ALU_SRL, ALU_SRA, ALU_ROR, ALU_ROL, ALU_SLT, ALU_SLTU};
    uop_t cfu_ops [9]  = '{CFU_BEQ, CFU_BNE, CFU_BLT, CFU_BGE, CFU_BLTU, CFU_BGEU,
                           CFU_JALI, CFU_JALR, CFU_JMP};

    tb_clock u_clock (.g_clk(g_clk), .g_resetn(g_resetn));

    exu_top dut_i (
        .g_clk(g_clk), .g_resetn(g_resetn),
        .i_s2_valid(s2_valid), .i_s2_rd(s2_rd), .i_s2_opr_a(s2_opr_a),
        .i_s2_opr_b(s2_opr_b), .i_s2_opr_c(s2_opr_c), .i_s2_uop(s2_uop),
        .i_s2_fu(s2_fu), .i_s2_trap(s2_trap), .i_s2_size(s2_size),
        .i_s2_instr(s2_instr), .i_flush(flush), .o_s2_busy(s2_busy),
        .i_s3_busy(s3_busy), .o_s3_valid(s3_valid), .o_s3_rd(s3_rd),
        .o_s3_uop(s3_uop), .o_s3_fu(s3_fu), .o_s3_trap(s3_trap),
        .o_s3_size(s3_size), .o_s3_instr(s3_instr),
        .o_s3_opr_a(s3_opr_a), .o_s3_opr_b(s3_opr_b),
        .o_fwd_rd(fwd_rd), .o_fwd_wdata(fwd_wdata),
        .o_fwd_load(fwd_load), .o_fwd_csr(fwd_csr)
    );

    // Compare tasks
    // --------------------
    task automatic check_word(input string name, input xword_t exp, input xword_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_uop(input string name, input uop_t exp, input uop_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_fu(input string name, input fu_t exp, input fu_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_size(input string name, input size_t exp, input size_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic fail_timeout(input string msg);
        errors++;                                           // Never a clean end
        $display("TIMEOUT at %0t: %s", $time, msg);
        $display("Test failed");
        $finish;
    endtask

    // Reference model
    // --------------------
    function automatic int rand_below(input int n);
        xword_t r;
        r = $random(seed);
        return int'(r[15:0]) % n;
    endfunction

    function automatic xword_t alu_model(input uop_t uop, input xword_t a, input xword_t b);
        logic [4:0] sh;
        sh = b[4:0];                                        // Low five bits only
        case (uop)
            ALU_SUB:  return a - b;
            ALU_XOR:  return a ^ b;
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            ALU_SLL:  return a << sh;
            ALU_SRL:  return a >> sh;
            ALU_SRA:  return xword_t'($signed(a) >>> sh);
            ALU_ROR:  return (a >> sh) | (a << (6'd32 - sh));
            ALU_ROL:  return (a << sh) | (a >> (6'd32 - sh));
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:  return a + b;
        endcase
    endfunction

    function automatic logic branch_taken();
        case (s2_uop)
            CFU_BEQ:  return s2_opr_a == s2_opr_b;
            CFU_BNE:  return s2_opr_a != s2_opr_b;
            CFU_BLT:  return $signed(s2_opr_a) < $signed(s2_opr_b);
            CFU_BGE:  return $signed(s2_opr_a) >= $signed(s2_opr_b);
            CFU_BLTU: return s2_opr_a < s2_opr_b;
            default:  return s2_opr_a >= s2_opr_b;          // bgeu
        endcase
    endfunction

    function automatic xword_t exp_opr_a();
        if (s2_fu[FU_ALU]) return alu_model(s2_uop, s2_opr_a, s2_opr_b);
        if (s2_fu[FU_LSU]) return s2_opr_a + s2_opr_b;      // Address
        if (s2_fu[FU_CSR]) return s2_opr_a;
        if (s2_uop == CFU_JALR) return (s2_opr_a + s2_opr_b) & ~32'd1;
        return s2_opr_c & ~32'd1;                           // Branch / jump target
    endfunction

    function automatic uop_t exp_uop();
        if (s2_fu[FU_CFU] && s2_uop[4:3] == 2'b00) begin
            return branch_taken() ? CFU_TAKEN : CFU_NOT_TAKEN;
        end
        return s2_uop;
    endfunction

    // Stimulus
    // --------------------
    task automatic compare_s3();
        check_bit("o_s3_valid", m_valid, s3_valid);
        check_word("o_s3_opr_a", m_opr_a, s3_opr_a);
        check_word("o_s3_opr_b", m_opr_b, s3_opr_b);
        if (m_valid) begin
            check_addr("o_s3_rd", m_rd, s3_rd);
            check_uop("o_s3_uop", m_uop, s3_uop);
            check_fu("o_s3_fu", m_fu, s3_fu);
            check_size("o_s3_size", m_size, s3_size);
            check_bit("o_s3_trap", m_trap, s3_trap);
            check_word("o_s3_instr", m_instr, s3_instr);
        end
    endtask

    // One clock, entered and left at the falling edge
    task automatic cycle(input logic valid, input logic busy, input logic do_flush,
                         output logic acc);
        xword_t e_a;
        xword_t e_b;
        uop_t   e_uop;
        logic   ld_b;
        s2_valid = valid;
        s3_busy  = busy;
        flush    = do_flush;
        #1;
        acc   = valid && !(m_valid && busy);                // Transfer at next edge
        e_a   = exp_opr_a();
        e_uop = exp_uop();
        e_b   = s2_trap ? xword_t'(s2_rd) :
                ((s2_fu[FU_LSU] || s2_fu[FU_CSR]) ? s2_opr_c : '0);
        ld_b  = s2_trap || s2_fu[FU_CSR] || (s2_fu[FU_LSU] && s2_uop[LSU_STORE]);
        check_bit("o_s2_busy", m_valid && busy, s2_busy);
        if (valid) begin
            check_word("o_fwd_wdata", e_a, fwd_wdata);
            check_addr("o_fwd_rd", s2_rd, fwd_rd);
            check_bit("o_fwd_load", s2_fu[FU_LSU] && s2_uop[LSU_LOAD], fwd_load);
            check_bit("o_fwd_csr", s2_fu[FU_CSR], fwd_csr);
        end
        if (s3_valid && !busy) delivered++;                 // Downstream takes it
        @(posedge g_clk);
        if (acc) begin
            m_opr_a = e_a;
            if (ld_b) m_opr_b = e_b;
            m_rd    = s2_rd;
            m_uop   = e_uop;
            m_fu    = s2_fu;
            m_size  = s2_size;
            m_trap  = s2_trap;
            m_instr = s2_instr;
        end
        if (do_flush) m_valid = 1'b0;                       // Flush beats a load
        else if (!(m_valid && busy)) m_valid = valid;
        @(negedge g_clk);
        compare_s3();
    endtask

    task automatic new_op(input int unit, input uop_t uop, input logic trap);
        xword_t r;
        s2_opr_a = $random(seed);
        s2_opr_b = $random(seed);
        s2_opr_c = $random(seed);
        s2_instr = $random(seed);
        r        = $random(seed);
        s2_rd    = r[4:0];
        s2_size  = r[6:5];
        if (r[7]) s2_opr_b = s2_opr_a;                      // Equal operands now and then
        s2_fu       = '0;
        s2_fu[unit] = 1'b1;
        s2_uop      = uop;
        s2_trap     = trap;
    endtask

    task automatic new_random_op(input logic trap);
        int   unit;
        uop_t u;
        unit = rand_below(4);
        u    = uop_t'(rand_below(8));
        case (unit)
            FU_ALU:  u = alu_ops[rand_below(12)];
            FU_CFU:  u = cfu_ops[rand_below(9)];
            FU_LSU:  u = u | ((rand_below(2) == 0) ? LD_FLAG : ST_FLAG);
            default: ;                                      // CSR keeps raw code
        endcase
        new_op(unit, u, trap);
    endtask

    task automatic send_op(input int busy_pct);
        logic acc;
        int   n;
        acc = 1'b0;
        n   = 0;
        while (!acc && n < TIMEOUT_CYCLES) begin
            cycle(1'b1, rand_below(100) < busy_pct, 1'b0, acc);
            n++;
        end
        if (acc) sent++;
        else fail_timeout("an operation was never accepted by the stage");
    endtask

    task automatic drain();
        logic acc;
        int   n;
        n = 0;
        while (s3_valid && n < TIMEOUT_CYCLES) begin
            cycle(1'b0, 1'b0, 1'b0, acc);
            n++;
        end
        if (s3_valid) fail_timeout("the output stage never emptied");
    endtask

    task automatic end_test(input string name, input int err0);
        $display("%s done, %0d errors", name, errors - err0);
    endtask

    // Test sequence
    // --------------------
    initial begin
        int   err0;
        int   n;
        int   i;
        logic acc;
        seed     = 32'h2469_b900;
        errors   = 0;
        checks   = 0;
        s2_valid = 1'b0;
        flush    = 1'b0;
        s3_busy  = 1'b0;
        new_op(FU_ALU, ALU_ADD, 1'b0);
        n = 0;
        while (!g_resetn && n < TIMEOUT_CYCLES) begin
            @(negedge g_clk);
            n++;
        end
        if (!g_resetn) fail_timeout("reset was never released");
        @(negedge g_clk);
        m_valid = 1'b0;
        compare_s3();                                       // Reset state

        err0 = errors;
        for (i = 0; i < 60; i++) begin
            new_op(FU_ALU, alu_ops[rand_below(12)], 1'b0);
            send_op(0);
        end
        drain();
        end_test("alu_ops", err0);

        err0 = errors;
        for (i = 0; i < 60; i++) begin
            new_op(FU_CFU, cfu_ops[rand_below(9)], 1'b0);
            send_op(0);
        end
        drain();
        end_test("branch_jump", err0);

        err0 = errors;
        for (i = 0; i < 80; i++) begin
            new_random_op(1'b0);
            send_op(0);
        end
        drain();
        end_test("lsu_csr", err0);

        err0      = errors;
        sent      = 0;
        delivered = 0;
        for (i = 0; i < 100; i++) begin
            if (rand_below(4) == 0) begin
                cycle(1'b0, rand_below(100) < 60, 1'b0, acc);  // Upstream idle
            end else begin
                new_random_op(1'b0);
                send_op(60);
            end
        end
        drain();
        check_word("items delivered", xword_t'(sent), xword_t'(delivered));
        end_test("back_pressure", err0);

        err0 = errors;
        for (i = 0; i < 20; i++) begin
            new_random_op(1'b0);
            send_op(0);
            new_random_op(1'b0);
            cycle(1'b1, rand_below(2) == 1, 1'b1, acc);        // Flush with a new op
            check_bit("o_s3_valid after flush", 1'b0, s3_valid);
            cycle(1'b0, 1'b0, 1'b0, acc);
        end
        end_test("flush", err0);

        err0 = errors;
        for (i = 0; i < 30; i++) begin
            new_random_op(1'b1);
            send_op(0);
        end
        drain();
        s2_trap = 1'b0;
        end_test("trap", err0);

        $display("Summary: 6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+source
source/exu_pkg.sv
source/exu_decode.sv
source/exu_alu.sv
source/exu_result.sv
source/exu_pipe_reg.sv
source/exu_top.sv
tests/tb_clock.sv
tests/tb_exu.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the execute stage testbench with Verilator and runs it.
# The run counts as failed when the log holds the fail message.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_exu -f build.f -o sim_exu

./obj_dir/sim_exu 2>&1 | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"
